// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_stepper_io
FILELIST  = stepper_io.f

SOURCES = $(shell grep -v '^+' $(FILELIST)) stepper_io_defs.svh
BIN     = obj_dir/V$(TOP)
LOG     = sim.log

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	$(BIN) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: io_bus_ctrl.sv
// four-phase req/ack responder, peripheral address decoder and read data register
`timescale 1ns/10ps
`default_nettype none
`include "stepper_io_defs.svh"

module io_bus_ctrl (
  input  logic                      clk_25mhz,
  input  logic                      rst_n,
  input  logic                      req,
  input  logic                      we,
  input  stepper_io_pkg::bus_addr_t addr,
  input  stepper_io_pkg::bus_word_t wdata,
  output logic                      ack,
  output stepper_io_pkg::bus_word_t rdata,
  io_bus_if.ctrl                    spi_bus,
  io_bus_if.ctrl                    step_bus
);

  // step window starts at the first period register
  localparam stepper_io_pkg::bus_addr_t step_base = `REG_STEP_PERIOD;
  localparam stepper_io_pkg::bus_addr_t step_span =
    stepper_io_pkg::bus_addr_t'(8 * `STEP_CHANNELS);

  stepper_io_pkg::bus_state_t state;
  stepper_io_pkg::bus_addr_t  step_off;
  stepper_io_pkg::bus_word_t  read_mux;
  logic                       spi_hit;
  logic                       step_hit;
  logic                       in_access;

  // handshake
  always_ff @(posedge clk_25mhz) begin
    if (!rst_n) begin
      state <= stepper_io_pkg::idle;
    end else begin
      case (state)
        stepper_io_pkg::idle: begin
          if (req) begin
            state <= stepper_io_pkg::access;
          end
        end
        stepper_io_pkg::access: begin
          state <= stepper_io_pkg::ack;
        end
        stepper_io_pkg::ack: begin
          // hold while the master keeps req up
          if (!req) begin
            state <= stepper_io_pkg::idle;
          end
        end
        default: begin
          state <= stepper_io_pkg::idle;
        end
      endcase
    end
  end

  assign in_access = (state == stepper_io_pkg::access);
  assign ack       = (state == stepper_io_pkg::ack);

  // address decode
  assign spi_hit  = (addr < step_base);
  assign step_off = addr - step_base;
  assign step_hit = !spi_hit && (step_off < step_span);

  // master holds we/addr/wdata stable for the whole access
  assign spi_bus.sel   = in_access && spi_hit;
  assign spi_bus.we    = we;
  assign spi_bus.idx   = addr[5:2];
  assign spi_bus.wdata = wdata;

  assign step_bus.sel   = in_access && step_hit;
  assign step_bus.we    = we;
  assign step_bus.idx   = step_off[5:2];
  assign step_bus.wdata = wdata;

  // unmapped addresses read 0
  always_comb begin
    if (spi_hit) begin
      read_mux = spi_bus.rdata;
    end else if (step_hit) begin
      read_mux = step_bus.rdata;
    end else begin
      read_mux = '0;
    end
  end

  // valid from the rising ack onwards
  always_ff @(posedge clk_25mhz) begin
    if (in_access) begin
      rdata <= read_mux;
    end
  end

endmodule

`default_nettype wire

// File: io_bus_if.sv
// register access interface between the bus controller and one peripheral
`timescale 1ns/10ps
`default_nettype none

interface io_bus_if;

  // one-cycle access strobe
  logic                      sel;
  logic                      we;
  stepper_io_pkg::reg_index_t idx;
  stepper_io_pkg::bus_word_t  wdata;
  // combinational read data from the peripheral
  stepper_io_pkg::bus_word_t  rdata;

  modport ctrl (
    output sel, we, idx, wdata,
    input  rdata
  );

  modport periph (
    input  sel, we, idx, wdata,
    output rdata
  );

endinterface

`default_nettype wire

// File: spi_master.sv
// SPI master with tx/rx/control registers, mode-0 shift engine, sck divider, cs decode
`timescale 1ns/10ps
`default_nettype none
`include "stepper_io_defs.svh"

module spi_master (
  input  logic                     clk_25mhz,
  input  logic                     rst_n,
  input  logic                     miso,
  output logic                     sck,
  output logic                     mosi,
  output logic [`SPI_CS_COUNT-1:0] cs_n,
  io_bus_if.periph                 bus
);

  localparam int hi_bits = `SPI_FRAME_BITS - 32;
  localparam int div_w   = $clog2(`SPI_HALF_DIV + 1);
  localparam int cnt_w   = $clog2(`SPI_FRAME_BITS + 1);

  localparam stepper_io_pkg::reg_index_t idx_tx_lo  = 4'(`REG_SPI_TX_LO >> 2);
  localparam stepper_io_pkg::reg_index_t idx_tx_hi  = 4'(`REG_SPI_TX_HI >> 2);
  localparam stepper_io_pkg::reg_index_t idx_rx_lo  = 4'(`REG_SPI_RX_LO >> 2);
  localparam stepper_io_pkg::reg_index_t idx_rx_hi  = 4'(`REG_SPI_RX_HI >> 2);
  localparam stepper_io_pkg::reg_index_t idx_ctrl   = 4'(`REG_SPI_CTRL >> 2);
  localparam stepper_io_pkg::reg_index_t idx_status = 4'(`REG_SPI_STATUS >> 2);

  stepper_io_pkg::bus_word_t  tx_lo;
  logic [hi_bits-1:0]         tx_hi;
  stepper_io_pkg::spi_frame_t rx;
  stepper_io_pkg::spi_frame_t shreg;
  stepper_io_pkg::cs_index_t  cs_idx;
  stepper_io_pkg::cs_index_t  cs_act;
  logic                       ready;
  logic                       miso_bit;
  logic                       ctrl_wr;
  logic                       start;
  logic                       half_done;
  logic [div_w-1:0]           div_cnt;
  logic [cnt_w-1:0]           bit_cnt;

  assign ctrl_wr   = bus.sel && bus.we && (bus.idx == idx_ctrl);
  // start is dropped while a frame is running
  assign start     = ctrl_wr && bus.wdata[4] && ready;
  assign half_done = (div_cnt == div_w'(`SPI_HALF_DIV - 1));

  always_ff @(posedge clk_25mhz) begin
    if (bus.sel && bus.we && bus.idx == idx_tx_lo) begin
      tx_lo <= bus.wdata;
    end
    if (bus.sel && bus.we && bus.idx == idx_tx_hi) begin
      tx_hi <= bus.wdata[hi_bits-1:0];
    end
  end

  always_ff @(posedge clk_25mhz) begin
    if (!rst_n) begin
      cs_idx <= '0;
    end else if (ctrl_wr) begin
      cs_idx <= bus.wdata[3:0];
    end
  end

  // divider, sck, bit counter and ready sequencing
  always_ff @(posedge clk_25mhz) begin
    if (!rst_n) begin
      ready   <= 1'b1;
      sck     <= 1'b0;
      div_cnt <= '0;
      bit_cnt <= '0;
    end else if (start) begin
      ready   <= 1'b0;
      sck     <= 1'b0;
      div_cnt <= '0;
      bit_cnt <= '0;
    end else if (!ready) begin
      if (half_done) begin
        div_cnt <= '0;
        sck     <= !sck;
        if (sck) begin
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == cnt_w'(`SPI_FRAME_BITS - 1)) begin
            ready <= 1'b1;
          end
        end
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  // sample miso on the rising sck and shift on the falling sck
  always_ff @(posedge clk_25mhz) begin
    if (start) begin
      shreg  <= {tx_hi, tx_lo};
      cs_act <= bus.wdata[3:0];
    end else if (!ready && half_done) begin
      if (!sck) begin
        miso_bit <= miso;
      end else begin
        shreg <= {shreg[`SPI_FRAME_BITS-2:0], miso_bit};
        if (bit_cnt == cnt_w'(`SPI_FRAME_BITS - 1)) begin
          rx <= {shreg[`SPI_FRAME_BITS-2:0], miso_bit};
        end
      end
    end
  end

  assign mosi = !ready && shreg[`SPI_FRAME_BITS-1];

  // out-of-range index selects nothing
  always_comb begin
    for (int i = 0; i < `SPI_CS_COUNT; i++) begin
      cs_n[i] = !(!ready && cs_act == 4'(i));
    end
  end

  always_comb begin
    case (bus.idx)
      idx_tx_lo:  bus.rdata = tx_lo;
      idx_tx_hi:  bus.rdata = {{(32 - hi_bits){1'b0}}, tx_hi};
      idx_rx_lo:  bus.rdata = rx[31:0];
      idx_rx_hi:  bus.rdata = {{(32 - hi_bits){1'b0}}, rx[`SPI_FRAME_BITS-1:32]};
      idx_ctrl:   bus.rdata = {28'b0, cs_idx};
      idx_status: bus.rdata = {31'b0, ready};
      default:    bus.rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: step_gen.sv
// per-axis step period and count registers with step pulse timers
`timescale 1ns/10ps
`default_nettype none
`include "stepper_io_defs.svh"

module step_gen (
  input  logic                      clk_25mhz,
  input  logic                      rst_n,
  output logic [`STEP_CHANNELS-1:0] step,
  output logic [`STEP_CHANNELS-1:0] dir,
  io_bus_if.periph                  bus
);

  stepper_io_pkg::step_period_t period [`STEP_CHANNELS];
  stepper_io_pkg::step_period_t timer  [`STEP_CHANNELS];
  stepper_io_pkg::step_count_t  count  [`STEP_CHANNELS];
  logic                         wr;

  assign wr = bus.sel && bus.we;

  // idx bit 0 picks ctrl over period, upper bits pick the axis
  always_ff @(posedge clk_25mhz) begin
    if (!rst_n) begin
      for (int ch = 0; ch < `STEP_CHANNELS; ch++) begin
        period[ch] <= '0;
        timer[ch]  <= '0;
        count[ch]  <= '0;
        dir[ch]    <= 1'b0;
        step[ch]   <= 1'b0;
      end
    end else begin
      for (int ch = 0; ch < `STEP_CHANNELS; ch++) begin
        step[ch] <= 1'b0;
        if (wr && bus.idx[3:1] == 3'(ch) && !bus.idx[0]) begin
          period[ch] <= bus.wdata[15:0];
        end
        if (wr && bus.idx[3:1] == 3'(ch) && bus.idx[0]) begin
          dir[ch]   <= bus.wdata[0];
          count[ch] <= bus.wdata[31:16];
          timer[ch] <= '0;
        end else if (count[ch] != '0) begin
          // one pulse every period+1 cycles
          if (timer[ch] == period[ch]) begin
            timer[ch] <= '0;
            step[ch]  <= 1'b1;
            count[ch] <= count[ch] - 1'b1;
          end else begin
            timer[ch] <= timer[ch] + 1'b1;
          end
        end
      end
    end
  end

  always_comb begin
    bus.rdata = '0;
    for (int ch = 0; ch < `STEP_CHANNELS; ch++) begin
      if (bus.idx[3:1] == 3'(ch)) begin
        // ctrl reads back the live remaining count
        bus.rdata = bus.idx[0] ? {count[ch], 15'b0, dir[ch]} : {16'b0, period[ch]};
      end
    end
  end

endmodule

`default_nettype wire

// File: stepper_io.f
+incdir+.
stepper_io_pkg.sv
io_bus_if.sv
io_bus_ctrl.sv
spi_master.sv
step_gen.sv
stepper_io.sv
tb_checker.sv
tb_stepper_io.sv

// File: stepper_io.sv
// top level of the I/O block: bus controller, SPI master and step generator
`timescale 1ns/10ps
`default_nettype none
`include "stepper_io_defs.svh"

module stepper_io (
  input  logic                      clk_25mhz,
  input  logic                      rst_n,
  // four-phase bus from the master
  input  logic                      req,
  input  logic                      we,
  input  stepper_io_pkg::bus_addr_t addr,
  input  stepper_io_pkg::bus_word_t wdata,
  output logic                      ack,
  output stepper_io_pkg::bus_word_t rdata,
  // SPI pins
  input  logic                      miso,
  output logic                      sck,
  output logic                      mosi,
  output logic [`SPI_CS_COUNT-1:0]  cs_n,
  // motor axes
  output logic [`STEP_CHANNELS-1:0] step,
  output logic [`STEP_CHANNELS-1:0] dir
);

  io_bus_if spi_bus ();
  io_bus_if step_bus ();

  io_bus_ctrl io_bus_ctrl_i (
    .clk_25mhz (clk_25mhz),
    .rst_n     (rst_n),
    .req       (req),
    .we        (we),
    .addr      (addr),
    .wdata     (wdata),
    .ack       (ack),
    .rdata     (rdata),
    .spi_bus   (spi_bus.ctrl),
    .step_bus  (step_bus.ctrl)
  );

  spi_master spi_master_i (
    .clk_25mhz (clk_25mhz),
    .rst_n     (rst_n),
    .miso      (miso),
    .sck       (sck),
    .mosi      (mosi),
    .cs_n      (cs_n),
    .bus       (spi_bus.periph)
  );

  step_gen step_gen_i (
    .clk_25mhz (clk_25mhz),
    .rst_n     (rst_n),
    .step      (step),
    .dir       (dir),
    .bus       (step_bus.periph)
  );

endmodule

`default_nettype wire

// File: stepper_io_defs.svh
// size, SPI clock divider and register offset macros for the stepper I/O block
`ifndef STEPPER_IO_DEFS_SVH
`define STEPPER_IO_DEFS_SVH

// SPI frame and chip selects
`define SPI_FRAME_BITS 40
`define SPI_CS_COUNT 12
// clock cycles per sck half period
`define SPI_HALF_DIV 4

// number of step/dir axes
`define STEP_CHANNELS 2

// byte offsets on the I/O bus
`define REG_SPI_TX_LO 8'h00
`define REG_SPI_TX_HI 8'h04
`define REG_SPI_RX_LO 8'h08
`define REG_SPI_RX_HI 8'h0C
`define REG_SPI_CTRL 8'h10
`define REG_SPI_STATUS 8'h14
// axis ch sits at these plus 8*ch
`define REG_STEP_PERIOD 8'h20
`define REG_STEP_CTRL 8'h24

`endif

// File: stepper_io_pkg.sv
// shared vector typedefs and the bus handshake state enum
`default_nettype none

package stepper_io_pkg;

`include "stepper_io_defs.svh"

  // bus side
  typedef logic [7:0] bus_addr_t;
  typedef logic [31:0] bus_word_t;
  // word index inside one peripheral window
  typedef logic [3:0] reg_index_t;

  // SPI
  typedef logic [`SPI_FRAME_BITS-1:0] spi_frame_t;
  typedef logic [3:0] cs_index_t;

  // step generator
  typedef logic [15:0] step_count_t;
  typedef logic [15:0] step_period_t;

  // four-phase responder states
  typedef enum logic [1:0] {
    idle,
    access,
    ack
  } bus_state_t;

endpackage

`default_nettype wire

// File: tb_checker.sv
// monitor comparing read data, checking the handshake and counting step pulses, SPI frames and sck edges
`timescale 1ns/10ps
`default_nettype none
`include "stepper_io_defs.svh"

module tb_checker (
  input  logic                      clk_25mhz,
  input  logic                      rst_n,
  input  logic                      req,
  input  logic                      ack,
  input  stepper_io_pkg::bus_word_t rdata,
  input  logic                      sck,
  input  logic                      mosi,
  input  logic [`SPI_CS_COUNT-1:0]  cs_n,
  input  logic [`STEP_CHANNELS-1:0] step,
  input  logic [`STEP_CHANNELS-1:0] dir,
  input  int                        row_no,
  input  logic                      row_valid,
  input  stepper_io_pkg::bus_word_t exp_rdata,
  input  logic                      cmp,
  input  logic                      done,
  input  int                        exp_steps [`STEP_CHANNELS],
  input  int                        exp_frames [`SPI_CS_COUNT],
  input  logic [`STEP_CHANNELS-1:0] exp_dir,
  output int                        errors
);

  int                       steps [`STEP_CHANNELS];
  int                       frames [`SPI_CS_COUNT];
  int                       checked;
  int                       sck_rises;
  int                       exp_rises;
  logic                     ack_q;
  logic                     req_q;
  logic                     rst_q;
  logic                     done_q;
  logic                     sck_q;
  logic [`SPI_CS_COUNT-1:0] cs_q;

  always @(posedge clk_25mhz) begin
    ack_q  <= ack;
    req_q  <= req;
    rst_q  <= rst_n;
    done_q <= done;
    sck_q  <= sck;
    cs_q   <= cs_n;
    if (!rst_n) begin
      errors    = 0;
      checked   = 0;
      sck_rises = 0;
      for (int ch = 0; ch < `STEP_CHANNELS; ch++) begin
        steps[ch] = 0;
      end
      for (int i = 0; i < `SPI_CS_COUNT; i++) begin
        frames[i] = 0;
      end
    end else begin
      // first sample after reset release
      if (!rst_q && (ack || cs_n != '1 || step != '0 || sck || mosi)) begin
        $display("reset state wrong: ack %b cs_n %b step %b sck %b mosi %b",
                 ack, cs_n, step, sck, mosi);
        errors = errors + 1;
      end
      for (int ch = 0; ch < `STEP_CHANNELS; ch++) begin
        if (step[ch]) begin
          steps[ch] = steps[ch] + 1;
        end
      end
      // one rising sck per frame bit
      if (sck && !sck_q) begin
        sck_rises = sck_rises + 1;
      end
      // a frame starts on a falling cs_n
      for (int i = 0; i < `SPI_CS_COUNT; i++) begin
        if (cs_q[i] && !cs_n[i]) begin
          frames[i] = frames[i] + 1;
        end
      end
      if (ack && !ack_q && row_valid) begin
        checked = checked + 1;
        if (!cmp) begin
          $display("row %0d: write done", row_no);
        end else if (rdata !== exp_rdata) begin
          $display("MISMATCH at %0t: row %0d read %08h, expected %08h",
                   $time, row_no, rdata, exp_rdata);
          errors = errors + 1;
        end else begin
          $display("row %0d: read %08h ok", row_no, rdata);
        end
      end
      if (ack_q && req_q && !ack) begin
        $display("ack dropped at %0t while req was still held", $time);
        errors = errors + 1;
      end
      if (done && !done_q) begin
        for (int ch = 0; ch < `STEP_CHANNELS; ch++) begin
          if (steps[ch] != exp_steps[ch]) begin
            $display("MISMATCH at %0t: axis %0d gave %0d step pulses, expected %0d",
                     $time, ch, steps[ch], exp_steps[ch]);
            errors = errors + 1;
          end
        end
        exp_rises = 0;
        for (int i = 0; i < `SPI_CS_COUNT; i++) begin
          if (frames[i] != exp_frames[i]) begin
            $display("MISMATCH at %0t: cs_n[%0d] saw %0d frames, expected %0d",
                     $time, i, frames[i], exp_frames[i]);
            errors = errors + 1;
          end
          exp_rises = exp_rises + exp_frames[i] * `SPI_FRAME_BITS;
        end
        if (sck_rises != exp_rises) begin
          $display("MISMATCH at %0t: sck rose %0d times, expected %0d",
                   $time, sck_rises, exp_rises);
          errors = errors + 1;
        end
        if (dir !== exp_dir) begin
          $display("MISMATCH at %0t: dir is %b, expected %b", $time, dir, exp_dir);
          errors = errors + 1;
        end
        $write("rows checked %0d, errors %0d, steps", checked, errors);
        for (int ch = 0; ch < `STEP_CHANNELS; ch++) begin
          $write(" %0d", steps[ch]);
        end
        $write(", frames");
        for (int i = 0; i < `SPI_CS_COUNT; i++) begin
          $write(" %0d", frames[i]);
        end
        $write(", sck rises %0d", sck_rises);
        $display("");
      end
    end
  end

endmodule

`default_nettype wire

// File: tb_stepper_io.sv
// testbench top for the stepper I/O block: clock, reset, stimulus table, bus driver, watchdog
`timescale 1ns/10ps
`default_nettype none
`include "stepper_io_defs.svh"

module tb_stepper_io;

  localparam int n_rows = 23;

  typedef struct packed {
    logic                      we;
    stepper_io_pkg::bus_addr_t addr;
    stepper_io_pkg::bus_word_t wdata;
    stepper_io_pkg::bus_word_t exp;
    logic                      cmp;
    logic                      wait_rdy;
  } row_t;

  logic                             clk_25mhz = 1'b0;
  logic                             rst_n;
  logic                             req;
  logic                             we;
  stepper_io_pkg::bus_addr_t        addr;
  stepper_io_pkg::bus_word_t        wdata;
  logic                             ack;
  stepper_io_pkg::bus_word_t        rdata;
  logic                             miso;
  logic                             sck;
  logic                             mosi;
  logic [`SPI_CS_COUNT-1:0]         cs_n;
  logic [`STEP_CHANNELS-1:0]        step;
  logic [`STEP_CHANNELS-1:0]        dir;
  // row info handed to the checker together with each access
  int                               row_no;
  logic                             row_valid;
  stepper_io_pkg::bus_word_t        exp_rdata;
  logic                             cmp;
  logic                             done;
  int                               exp_steps [`STEP_CHANNELS];
  int                               exp_frames [`SPI_CS_COUNT];
  logic [`STEP_CHANNELS-1:0]        exp_dir;
  int                               errors;
  integer                           seed;
  row_t                             rows [n_rows];

  always #20 clk_25mhz = ~clk_25mhz;

  // SPI loopback
  assign miso = mosi;

  stepper_io stepper_io_i (
    .clk_25mhz (clk_25mhz),
    .rst_n     (rst_n),
    .req       (req),
    .we        (we),
    .addr      (addr),
    .wdata     (wdata),
    .ack       (ack),
    .rdata     (rdata),
    .miso      (miso),
    .sck       (sck),
    .mosi      (mosi),
    .cs_n      (cs_n),
    .step      (step),
    .dir       (dir)
  );

  tb_checker checker_i (
    .clk_25mhz  (clk_25mhz),
    .rst_n      (rst_n),
    .req        (req),
    .ack        (ack),
    .rdata      (rdata),
    .sck        (sck),
    .mosi       (mosi),
    .cs_n       (cs_n),
    .step       (step),
    .dir        (dir),
    .row_no     (row_no),
    .row_valid  (row_valid),
    .exp_rdata  (exp_rdata),
    .cmp        (cmp),
    .done       (done),
    .exp_steps  (exp_steps),
    .exp_frames (exp_frames),
    .exp_dir    (exp_dir),
    .errors     (errors)
  );

  task set_row(input int r, input logic w, input stepper_io_pkg::bus_addr_t a,
               input stepper_io_pkg::bus_word_t d, input stepper_io_pkg::bus_word_t e,
               input logic c, input logic wt);
    rows[r] = '{w, a, d, e, c, wt};
  endtask

  // we, addr, wdata, expected read, compare, wait for SPI ready first
  task load_table;
    set_row(0, 1'b0, `REG_SPI_STATUS, 32'h0, 32'h1, 1'b1, 1'b0);
    set_row(1, 1'b0, 8'h18, 32'h0, 32'h0, 1'b1, 1'b0);
    set_row(2, 1'b1, `REG_STEP_PERIOD, 32'd9, 32'h0, 1'b0, 1'b0);
    set_row(3, 1'b0, `REG_STEP_PERIOD, 32'h0, 32'd9, 1'b1, 1'b0);
    set_row(4, 1'b1, `REG_STEP_PERIOD + 8'h08, 32'd2, 32'h0, 1'b0, 1'b0);
    set_row(5, 1'b0, `REG_STEP_PERIOD + 8'h08, 32'h0, 32'd2, 1'b1, 1'b0);
    // five steps on axis 0 with dir 1
    set_row(6, 1'b1, `REG_STEP_CTRL, 32'h0005_0001, 32'h0, 1'b0, 1'b0);
    set_row(7, 1'b1, `REG_SPI_TX_LO, 32'ha5c3_1e77, 32'h0, 1'b0, 1'b0);
    set_row(8, 1'b1, `REG_SPI_TX_HI, 32'hffff_ff3c, 32'h0, 1'b0, 1'b0);
    set_row(9, 1'b0, `REG_SPI_TX_LO, 32'h0, 32'ha5c3_1e77, 1'b1, 1'b0);
    set_row(10, 1'b0, `REG_SPI_TX_HI, 32'h0, 32'h0000_003c, 1'b1, 1'b0);
    set_row(11, 1'b1, `REG_SPI_CTRL, 32'h15, 32'h0, 1'b0, 1'b0);
    // new tx data and a second start while the frame is running
    set_row(12, 1'b1, `REG_SPI_TX_LO, 32'h1234_5678, 32'h0, 1'b0, 1'b0);
    set_row(13, 1'b1, `REG_SPI_CTRL, 32'h19, 32'h0, 1'b0, 1'b0);
    set_row(14, 1'b0, `REG_SPI_STATUS, 32'h0, 32'h0, 1'b1, 1'b0);
    set_row(15, 1'b0, `REG_SPI_CTRL, 32'h0, 32'h9, 1'b1, 1'b1);
    set_row(16, 1'b0, `REG_SPI_RX_LO, 32'h0, 32'ha5c3_1e77, 1'b1, 1'b0);
    set_row(17, 1'b0, `REG_SPI_RX_HI, 32'h0, 32'h0000_003c, 1'b1, 1'b0);
    set_row(18, 1'b0, `REG_SPI_TX_LO, 32'h0, 32'h1234_5678, 1'b1, 1'b0);
    set_row(19, 1'b0, `REG_STEP_CTRL, 32'h0, 32'h0000_0001, 1'b1, 1'b0);
    set_row(20, 1'b0, `REG_STEP_CTRL + 8'h08, 32'h0, 32'h0, 1'b1, 1'b0);
    set_row(21, 1'b1, 8'h30, 32'hdead_beef, 32'h0, 1'b0, 1'b0);
    set_row(22, 1'b0, 8'h30, 32'h0, 32'h0, 1'b1, 1'b0);
    for (int i = 0; i < `SPI_CS_COUNT; i++) begin
      exp_frames[i] = (i == 5) ? 1 : 0;
    end
    exp_steps[0] = 5;
    exp_steps[1] = 0;
    exp_dir = 2'b01;
  endtask

  // one four-phase access, or a status poll that the checker ignores
  task run_access(input int r, input logic poll, output stepper_io_pkg::bus_word_t rd);
    int extra;
    @(posedge clk_25mhz);
    req       <= 1'b1;
    we        <= poll ? 1'b0 : rows[r].we;
    addr      <= poll ? `REG_SPI_STATUS : rows[r].addr;
    wdata     <= poll ? 32'h0 : rows[r].wdata;
    row_no    <= r;
    row_valid <= !poll;
    exp_rdata <= rows[r].exp;
    cmp       <= rows[r].cmp;
    do @(posedge clk_25mhz); while (!ack);
    rd = rdata;
    // hold req a little past ack
    extra = $unsigned($random(seed)) % 4;
    repeat (extra) @(posedge clk_25mhz);
    req <= 1'b0;
    do @(posedge clk_25mhz); while (ack);
  endtask

  initial begin
    stepper_io_pkg::bus_word_t rd;
    rst_n     = 1'b0;
    req       = 1'b0;
    we        = 1'b0;
    addr      = '0;
    wdata     = '0;
    row_no    = 0;
    row_valid = 1'b0;
    exp_rdata = '0;
    cmp       = 1'b0;
    done      = 1'b0;
    seed      = 91;
    load_table();
    repeat (4) @(posedge clk_25mhz);
    rst_n <= 1'b1;
    for (int r = 0; r < n_rows; r++) begin
      if (rows[r].wait_rdy) begin
        rd = '0;
        while (!rd[0]) begin
          run_access(r, 1'b1, rd);
        end
      end
      run_access(r, 1'b0, rd);
    end
    @(posedge clk_25mhz);
    done <= 1'b1;
    repeat (2) @(posedge clk_25mhz);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog sized for one full SPI frame per row
  initial begin
    repeat (n_rows * 400) @(posedge clk_25mhz);
    $display("timeout: the table did not finish within %0d clock cycles", n_rows * 400);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire
